/* hdl/bus_cmd_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface bus_cmd_if;
   import fabric_pkg::*;

   logic       wr;    // one-cycle write strobe
   logic       rd;    // one-cycle read strobe
   addr_t      addr;
   word_t      wdata;
   logic [3:0] be;

   modport decoder (
      output wr,
      output rd,
      output addr,
      output wdata,
      output be
   );

   modport sink (
      input wr,
      input rd,
      input addr,
      input wdata,
      input be
   );

endinterface

`default_nettype wire

/* hdl/bus_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_decode (
   input  logic              CLK,
   input  logic              rst,
   input  logic              lint_req,
   input  logic              lint_wen,
   input  fabric_pkg::addr_t lint_addr,
   input  fabric_pkg::word_t lint_wdata,
   input  logic [3:0]        lint_be,
   output logic              lint_gnt,
   output logic              lint_valid,
   bus_cmd_if.decoder        cmd
);
   import fabric_pkg::*;

   logic [1:0] state;
   logic       accept;

   assign accept = (state == ST_IDLE) && lint_req && !lint_gnt;

   always_ff @(posedge CLK) begin
      if (rst) begin
         state      <= ST_IDLE;
         lint_gnt   <= 1'b0;
         lint_valid <= 1'b0;
         cmd.wr     <= 1'b0;
         cmd.rd     <= 1'b0;
      end else begin
         lint_valid <= lint_gnt; // valid trails gnt by one
         lint_gnt   <= 1'b0;
         cmd.wr     <= accept && !lint_wen;
         cmd.rd     <= accept && lint_wen;
         case (state)
            ST_IDLE: begin
               if (accept) begin
                  if (!lint_wen) begin
                     lint_gnt <= 1'b1; // write granted at once
                     state    <= ST_WRITE;
                  end else begin
                     state <= ST_READ;
                  end
               end
            end
            ST_WRITE: begin
               state <= ST_IDLE;
            end
            ST_READ: begin
               state <= ST_RDWAIT; // read_mux loads rdata here
            end
            ST_RDWAIT: begin
               lint_gnt <= 1'b1;
               state    <= ST_IDLE;
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   // sampled access
   always_ff @(posedge CLK) begin
      if (accept) begin
         cmd.addr  <= lint_addr;
         cmd.wdata <= lint_wdata;
         cmd.be    <= lint_be;
      end
   end

   a_gnt_valid: assert property (@(posedge CLK) disable iff (rst)
      !(lint_gnt && lint_valid));

   // read strobe alone, gnt two cycles later
   a_rd_gnt: assert property (@(posedge CLK) disable iff (rst)
      cmd.rd |-> !cmd.wr ##2 lint_gnt);

endmodule

`default_nettype wire

/* hdl/ctrl_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrl_regs (
   input  logic                  CLK,
   input  logic                  rst,
   bus_cmd_if.sink               cmd,
   output fabric_pkg::mac_ctrl_u mac_ctrl,
   output logic                  mac_clken,
   output fabric_pkg::io_t       io_out,
   output fabric_pkg::io_t       io_oe
);
   import fabric_pkg::*;

   word_t ctrl_merged;
   logic  ctrl_hit;
   logic  out_hit;
   logic  oe_hit;

   // put one bus word into the 32/32/16 slices of an io vector
   function automatic io_t put_slice(input io_t cur, input addr_t offs, input word_t wd);
      io_t nxt;
      nxt = cur;
      case (offs)
         20'h0: begin
            nxt[31:0] = wd;
         end
         20'h4: begin
            nxt[63:32] = wd;
         end
         20'h8: begin
            nxt[79:64] = wd[15:0]; // upper half dropped
         end
         default: begin
            nxt = cur;
         end
      endcase
      return nxt;
   endfunction

   always_comb begin
      for (int i = 0; i < 4; i++) begin
         if (cmd.be[i]) begin
            ctrl_merged[8*i +: 8] = cmd.wdata[8*i +: 8];
         end else begin
            ctrl_merged[8*i +: 8] = mac_ctrl.raw[8*i +: 8];
         end
      end
   end

   assign ctrl_hit = cmd.wr && (cmd.addr == A_MAC_CTRL);
   assign out_hit  = cmd.wr && (cmd.addr inside {[A_IO_OUT : A_IO_OUT + 20'h8]});
   assign oe_hit   = cmd.wr && (cmd.addr inside {[A_IO_OE : A_IO_OE + 20'h8]});

   always_ff @(posedge CLK) begin
      if (rst) begin
         mac_ctrl  <= '0;
         mac_clken <= 1'b0;
         io_out    <= '0;
         io_oe     <= '0;
      end else begin
         mac_clken <= cmd.wr && (cmd.addr == A_MAC_CLKEN); // single pulse
         if (ctrl_hit) begin
            mac_ctrl.raw <= ctrl_merged;
         end
         if (out_hit) begin
            io_out <= put_slice(io_out, cmd.addr - A_IO_OUT, cmd.wdata);
         end
         if (oe_hit) begin
            io_oe <= put_slice(io_oe, cmd.addr - A_IO_OE, cmd.wdata);
         end
      end
   end

   a_clken_pulse: assert property (@(posedge CLK) disable iff (rst)
      mac_clken |=> !mac_clken);

endmodule

`default_nettype wire

/* hdl/fabric_pkg.sv */
`default_nettype none

package fabric_pkg;

   typedef logic [19:0] addr_t;
   typedef logic [31:0] word_t;
   typedef logic [79:0] io_t;

   localparam int N_TCDM = 2;

   localparam addr_t A_TCDM_CFG  = 20'h00000; // plus 4 per port
   localparam addr_t A_MAC_CTRL  = 20'h00010;
   localparam addr_t A_MAC_CLKEN = 20'h00030;
   localparam addr_t A_IO_OUT    = 20'h00040; // 3 words
   localparam addr_t A_IO_OE     = 20'h00050;
   localparam addr_t A_IO_IN     = 20'h00060;
   localparam addr_t A_TCDM_DATA = 20'h00080; // plus 4 per port
   localparam addr_t A_ID        = 20'h00800;

   localparam word_t ID_WORD = 32'hca11ef3a;

   // bus access states
   localparam logic [1:0] ST_IDLE   = 2'd0;
   localparam logic [1:0] ST_WRITE  = 2'd1;
   localparam logic [1:0] ST_READ   = 2'd2;
   localparam logic [1:0] ST_RDWAIT = 2'd3;

   typedef struct packed {
      logic        reset;
      logic [11:0] pad_hi;
      logic        sat;
      logic        clr;
      logic        rnd;
      logic        csel;
      logic        osel;
      logic [1:0]  mode;
      logic [4:0]  pad_lo;
      logic        tc;
      logic [5:0]  outsel;
   } mac_ctrl_t;

   typedef union packed {
      word_t     raw;
      mac_ctrl_t f;
   } mac_ctrl_u;

   typedef struct packed {
      logic       wen;  // 1 = read
      logic [6:0] pad;
      logic [3:0] be_n; // inverted byte enables
      addr_t      addr;
   } tcdm_cfg_t;

   typedef union packed {
      word_t     raw;
      tcdm_cfg_t f;
   } tcdm_cfg_u;

endpackage

`default_nettype wire

/* hdl/fabric_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fabric_top (
   input  logic              CLK,
   input  logic              rst,
   input  logic              lint_req,
   input  logic              lint_wen,
   input  fabric_pkg::addr_t lint_addr,
   input  fabric_pkg::word_t lint_wdata,
   input  logic [3:0]        lint_be,
   output logic              lint_gnt,
   output logic              lint_valid,
   output fabric_pkg::word_t lint_rdata,
   input  fabric_pkg::io_t   fpgaio_in,
   output fabric_pkg::io_t   fpgaio_out,
   output fabric_pkg::io_t   fpgaio_oe,
   output logic [5:0]        mac_outsel,
   output logic              mac_tc,
   output logic [1:0]        mac_mode,
   output logic              mac_osel,
   output logic              mac_csel,
   output logic              mac_rnd,
   output logic              mac_clr,
   output logic              mac_sat,
   output logic              mac_reset,
   output logic              mac_clken,
   output fabric_pkg::addr_t tcdm_addr_p0,
   output fabric_pkg::word_t tcdm_wdata_p0,
   output logic [3:0]        tcdm_be_p0,
   output logic              tcdm_wen_p0,
   output logic              tcdm_req_p0,
   input  logic              tcdm_gnt_p0,
   input  logic              tcdm_valid_p0,
   input  fabric_pkg::word_t tcdm_rdata_p0,
   output fabric_pkg::addr_t tcdm_addr_p1,
   output fabric_pkg::word_t tcdm_wdata_p1,
   output logic [3:0]        tcdm_be_p1,
   output logic              tcdm_wen_p1,
   output logic              tcdm_req_p1,
   input  logic              tcdm_gnt_p1,
   input  logic              tcdm_valid_p1,
   input  fabric_pkg::word_t tcdm_rdata_p1
);
   import fabric_pkg::*;

   mac_ctrl_u mac_ctrl;
   tcdm_cfg_u cfg0;
   tcdm_cfg_u cfg1;
   word_t     result0;
   word_t     result1;

   bus_cmd_if cmd_if ();

   bus_decode decode_i (
      .CLK        (CLK),
      .rst        (rst),
      .lint_req   (lint_req),
      .lint_wen   (lint_wen),
      .lint_addr  (lint_addr),
      .lint_wdata (lint_wdata),
      .lint_be    (lint_be),
      .lint_gnt   (lint_gnt),
      .lint_valid (lint_valid),
      .cmd        (cmd_if.decoder)
   );

   ctrl_regs ctrl_i (
      .CLK       (CLK),
      .rst       (rst),
      .cmd       (cmd_if.sink),
      .mac_ctrl  (mac_ctrl),
      .mac_clken (mac_clken),
      .io_out    (fpgaio_out),
      .io_oe     (fpgaio_oe)
   );

   tcdm_port #(.PORT_IDX(0)) port0_i (
      .CLK    (CLK),
      .rst    (rst),
      .cmd    (cmd_if.sink),
      .cfg    (cfg0),
      .wdata  (tcdm_wdata_p0),
      .result (result0),
      .req    (tcdm_req_p0),
      .gnt    (tcdm_gnt_p0),
      .valid  (tcdm_valid_p0),
      .rdata  (tcdm_rdata_p0)
   );

   tcdm_port #(.PORT_IDX(1)) port1_i (
      .CLK    (CLK),
      .rst    (rst),
      .cmd    (cmd_if.sink),
      .cfg    (cfg1),
      .wdata  (tcdm_wdata_p1),
      .result (result1),
      .req    (tcdm_req_p1),
      .gnt    (tcdm_gnt_p1),
      .valid  (tcdm_valid_p1),
      .rdata  (tcdm_rdata_p1)
   );

   read_mux rmux_i (
      .CLK        (CLK),
      .rst        (rst),
      .cmd        (cmd_if.sink),
      .mac_ctrl   (mac_ctrl),
      .io_out     (fpgaio_out),
      .io_oe      (fpgaio_oe),
      .io_in      (fpgaio_in),
      .cfg0       (cfg0),
      .cfg1       (cfg1),
      .result0    (result0),
      .result1    (result1),
      .lint_rdata (lint_rdata)
   );

   assign mac_outsel = mac_ctrl.f.outsel;
   assign mac_tc     = mac_ctrl.f.tc;
   assign mac_mode   = mac_ctrl.f.mode;
   assign mac_osel   = mac_ctrl.f.osel;
   assign mac_csel   = mac_ctrl.f.csel;
   assign mac_rnd    = mac_ctrl.f.rnd;
   assign mac_clr    = mac_ctrl.f.clr;
   assign mac_sat    = mac_ctrl.f.sat;
   assign mac_reset  = mac_ctrl.f.reset;

   assign tcdm_addr_p0 = cfg0.f.addr;
   assign tcdm_be_p0   = ~cfg0.f.be_n; // stored inverted
   assign tcdm_wen_p0  = cfg0.f.wen;
   assign tcdm_addr_p1 = cfg1.f.addr;
   assign tcdm_be_p1   = ~cfg1.f.be_n;
   assign tcdm_wen_p1  = cfg1.f.wen;

endmodule

`default_nettype wire

/* hdl/read_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module read_mux (
   input  logic                  CLK,
   input  logic                  rst,
   bus_cmd_if.sink               cmd,
   input  fabric_pkg::mac_ctrl_u mac_ctrl,
   input  fabric_pkg::io_t       io_out,
   input  fabric_pkg::io_t       io_oe,
   input  fabric_pkg::io_t       io_in,
   input  fabric_pkg::tcdm_cfg_u cfg0,
   input  fabric_pkg::tcdm_cfg_u cfg1,
   input  fabric_pkg::word_t     result0,
   input  fabric_pkg::word_t     result1,
   output fabric_pkg::word_t     lint_rdata
);
   import fabric_pkg::*;

   word_t rd_word;

   always_comb begin
      case (cmd.addr)
         A_TCDM_CFG:            rd_word = cfg0.raw;
         A_TCDM_CFG + 20'h4:    rd_word = cfg1.raw;
         A_MAC_CTRL:            rd_word = mac_ctrl.raw;
         A_IO_OUT:              rd_word = io_out[31:0];
         A_IO_OUT + 20'h4:      rd_word = io_out[63:32];
         A_IO_OUT + 20'h8:      rd_word = {16'h0000, io_out[79:64]};
         A_IO_OE:               rd_word = io_oe[31:0];
         A_IO_OE + 20'h4:       rd_word = io_oe[63:32];
         A_IO_OE + 20'h8:       rd_word = {16'h0000, io_oe[79:64]};
         A_IO_IN:               rd_word = io_in[31:0];
         A_IO_IN + 20'h4:       rd_word = io_in[63:32];
         A_IO_IN + 20'h8:       rd_word = {16'h0000, io_in[79:64]};
         A_TCDM_DATA:           rd_word = result0;
         A_TCDM_DATA + 20'h4:   rd_word = result1;
         A_ID:                  rd_word = ID_WORD;
         default:               rd_word = '0; // unmapped
      endcase
   end

   // held until the next read so it stays valid through gnt and valid
   always_ff @(posedge CLK) begin
      if (rst) begin
         lint_rdata <= '0;
      end else if (cmd.rd) begin
         lint_rdata <= rd_word;
      end
   end

endmodule

`default_nettype wire

/* hdl/tcdm_port.sv */
`timescale 1ns/1ps
`default_nettype none

module tcdm_port #(
   parameter int PORT_IDX = 0
) (
   input  logic                  CLK,
   input  logic                  rst,
   bus_cmd_if.sink               cmd,
   output fabric_pkg::tcdm_cfg_u cfg,
   output fabric_pkg::word_t     wdata,
   output fabric_pkg::word_t     result,
   output logic                  req,
   input  logic                  gnt,
   input  logic                  valid,
   input  fabric_pkg::word_t     rdata
);
   import fabric_pkg::*;

   logic cfg_hit;
   logic launch;

   if (PORT_IDX < 0 || PORT_IDX >= N_TCDM) begin : g_bad_idx
      $error("tcdm_port: PORT_IDX out of range");
   end

   assign cfg_hit = cmd.wr && (cmd.addr == A_TCDM_CFG + addr_t'(4 * PORT_IDX));
   // kick ignored while a transfer is still pending
   assign launch  = cmd.wr && (cmd.addr == A_TCDM_DATA + addr_t'(4 * PORT_IDX)) && !req;

   always_ff @(posedge CLK) begin
      if (rst) begin
         cfg    <= '0;
         req    <= 1'b0;
         result <= '0;
      end else begin
         if (cfg_hit) begin
            cfg.raw <= cmd.wdata;
         end
         if (launch) begin
            req <= 1'b1;
         end else if (req && gnt) begin
            req <= 1'b0; // drop after grant edge
         end
         if (valid) begin
            result <= rdata;
         end
      end
   end

   always_ff @(posedge CLK) begin
      if (launch) begin
         wdata <= cmd.wdata;
      end
   end

   a_req_hold: assert property (@(posedge CLK) disable iff (rst)
      req && !gnt |=> req && $stable(cfg.f.addr) && $stable(wdata));

endmodule

`default_nettype wire

/* project.f */
+incdir+tb
hdl/fabric_pkg.sv
hdl/bus_cmd_if.sv
hdl/bus_decode.sv
hdl/ctrl_regs.sv
hdl/tcdm_port.sv
hdl/read_mux.sv
hdl/fabric_top.sv
tb/tb_top.sv

/* tb/fabric_model.svh */
`ifndef FABRIC_MODEL_SVH
`define FABRIC_MODEL_SVH

// register image as the bus master should see it
mac_ctrl_u m_mac;
io_t       m_out;
io_t       m_oe;
tcdm_cfg_u m_cfg [N_TCDM];
word_t     m_result [N_TCDM];

function automatic void model_reset();
   m_mac = '0;
   m_out = '0;
   m_oe  = '0;
   for (int p = 0; p < N_TCDM; p++) begin
      m_cfg[p]    = '0;
      m_result[p] = '0;
   end
endfunction

// slice s of an 80-bit vector holds 32, 32 or 16 bits
function automatic io_t io_slice_write(input io_t v, input int s, input word_t d);
   io_t r;
   r = v;
   if (s == 0) begin
      r[31:0] = d;
   end else if (s == 1) begin
      r[63:32] = d;
   end else begin
      r[79:64] = d[15:0];
   end
   return r;
endfunction

function automatic word_t io_slice_read(input io_t v, input int s);
   word_t r;
   r = '0;
   if (s == 0) begin
      r = v[31:0];
   end else if (s == 1) begin
      r = v[63:32];
   end else begin
      r[15:0] = v[79:64]; // zero padded
   end
   return r;
endfunction

function automatic void model_write(input addr_t a, input word_t d, input logic [3:0] be);
   for (int b = 0; b < 4; b++) begin
      if (a == A_MAC_CTRL && be[b]) begin
         m_mac.raw[b*8 +: 8] = d[b*8 +: 8];
      end
   end
   for (int s = 0; s < 3; s++) begin
      if (a == A_IO_OUT + addr_t'(4 * s)) begin
         m_out = io_slice_write(m_out, s, d);
      end
      if (a == A_IO_OE + addr_t'(4 * s)) begin
         m_oe = io_slice_write(m_oe, s, d);
      end
   end
   for (int p = 0; p < N_TCDM; p++) begin
      if (a == A_TCDM_CFG + addr_t'(4 * p)) begin
         m_cfg[p].raw = d; // whole word regardless of lanes
      end
   end
endfunction

function automatic word_t model_read(input addr_t a, input io_t in_pins);
   word_t r;
   r = '0; // unmapped
   if (a == A_ID) begin
      r = 32'hca11ef3a;
   end
   if (a == A_MAC_CTRL) begin
      r = m_mac.raw;
   end
   for (int p = 0; p < N_TCDM; p++) begin
      if (a == A_TCDM_CFG + addr_t'(4 * p)) begin
         r = m_cfg[p].raw;
      end
      if (a == A_TCDM_DATA + addr_t'(4 * p)) begin
         r = m_result[p];
      end
   end
   for (int s = 0; s < 3; s++) begin
      if (a == A_IO_OUT + addr_t'(4 * s)) begin
         r = io_slice_read(m_out, s);
      end
      if (a == A_IO_OE + addr_t'(4 * s)) begin
         r = io_slice_read(m_oe, s);
      end
      if (a == A_IO_IN + addr_t'(4 * s)) begin
         r = io_slice_read(in_pins, s);
      end
   end
   return r;
endfunction

task automatic check_bit(input string name, input logic got, input logic exp);
   if (got !== exp) begin
      stop_failed($sformatf("FAILED %s: got %h expected %h", name, got, exp));
   end
endtask

task automatic check_word(input string name, input word_t got, input word_t exp);
   if (got !== exp) begin
      stop_failed($sformatf("FAILED %s: got %h expected %h", name, got, exp));
   end
endtask

task automatic check_io(input string name, input io_t got, input io_t exp);
   if (got !== exp) begin
      stop_failed($sformatf("FAILED %s: got %h expected %h", name, got, exp));
   end
endtask

task automatic check_mac(input string name, input mac_ctrl_u got, input mac_ctrl_u exp);
   if (got.raw !== exp.raw) begin
      stop_failed($sformatf("FAILED %s: got %h expected %h", name, got.raw, exp.raw));
   end
endtask

task automatic check_cfg(input string name, input tcdm_cfg_u got, input tcdm_cfg_u exp);
   if (got.raw !== exp.raw) begin
      stop_failed($sformatf("FAILED %s: got %h expected %h", name, got.raw, exp.raw));
   end
endtask

`endif

/* tb/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top;
   import fabric_pkg::*;

   localparam int TIMEOUT = 40; // edges per wait
   localparam int N_OPS   = 300;

   logic       CLK;
   logic       rst;
   logic       lint_req;
   logic       lint_wen;
   addr_t      lint_addr;
   word_t      lint_wdata;
   logic [3:0] lint_be;
   logic       lint_gnt;
   logic       lint_valid;
   word_t      lint_rdata;
   io_t        fpgaio_in;
   io_t        fpgaio_out;
   io_t        fpgaio_oe;
   logic [5:0] mac_outsel;
   logic [1:0] mac_mode;
   logic       mac_tc;
   logic       mac_osel;
   logic       mac_csel;
   logic       mac_rnd;
   logic       mac_clr;
   logic       mac_sat;
   logic       mac_reset;
   logic       mac_clken;

   wire addr_t      mem_addr [N_TCDM];
   wire word_t      mem_wdata [N_TCDM];
   wire logic [3:0] mem_be [N_TCDM];
   wire logic       mem_wen [N_TCDM];
   wire logic       mem_req [N_TCDM];
   logic            mem_gnt [N_TCDM];
   logic            mem_valid [N_TCDM];
   word_t           mem_rdata [N_TCDM];

   int    seed = 32'h1105_1a7d;
   int    resp_seed = 32'h1105_1a7d; // responder has its own stream
   int    gnt_cnt [N_TCDM];
   int    val_cnt [N_TCDM];
   addr_t pend_addr [N_TCDM];

   task automatic stop_failed(input string why);
      $display("%s", why);
      $display(">>> FAIL");
      $fatal(1, "simulation stopped");
   endtask

`include "fabric_model.svh"

   fabric_top dut_i (
      .CLK (CLK), .rst (rst),
      .lint_req (lint_req), .lint_wen (lint_wen), .lint_addr (lint_addr),
      .lint_wdata (lint_wdata), .lint_be (lint_be), .lint_gnt (lint_gnt),
      .lint_valid (lint_valid), .lint_rdata (lint_rdata),
      .fpgaio_in (fpgaio_in), .fpgaio_out (fpgaio_out), .fpgaio_oe (fpgaio_oe),
      .mac_outsel (mac_outsel), .mac_tc (mac_tc), .mac_mode (mac_mode),
      .mac_osel (mac_osel), .mac_csel (mac_csel), .mac_rnd (mac_rnd),
      .mac_clr (mac_clr), .mac_sat (mac_sat), .mac_reset (mac_reset),
      .mac_clken (mac_clken),
      .tcdm_addr_p0 (mem_addr[0]), .tcdm_wdata_p0 (mem_wdata[0]), .tcdm_be_p0 (mem_be[0]),
      .tcdm_wen_p0 (mem_wen[0]), .tcdm_req_p0 (mem_req[0]), .tcdm_gnt_p0 (mem_gnt[0]),
      .tcdm_valid_p0 (mem_valid[0]), .tcdm_rdata_p0 (mem_rdata[0]),
      .tcdm_addr_p1 (mem_addr[1]), .tcdm_wdata_p1 (mem_wdata[1]), .tcdm_be_p1 (mem_be[1]),
      .tcdm_wen_p1 (mem_wen[1]), .tcdm_req_p1 (mem_req[1]), .tcdm_gnt_p1 (mem_gnt[1]),
      .tcdm_valid_p1 (mem_valid[1]), .tcdm_rdata_p1 (mem_rdata[1])
   );

   initial CLK = 1'b0;
   always #10 CLK = ~CLK;

   // memory responder grants after 0..3 cycles and raises valid 1..2 cycles later
   always @(posedge CLK) begin
      for (int p = 0; p < N_TCDM; p++) begin
         mem_gnt[p]   <= 1'b0;
         mem_valid[p] <= 1'b0;
         if (rst) begin
            gnt_cnt[p] = -1;
            val_cnt[p] = 0;
         end else begin
            if (val_cnt[p] > 0) begin
               val_cnt[p] = val_cnt[p] - 1;
               if (val_cnt[p] == 0) begin
                  mem_valid[p] <= 1'b1;
                  mem_rdata[p] <= {12'h000, pend_addr[p]} ^ 32'h5a5a_0000;
               end
            end
            if (gnt_cnt[p] < 0 && mem_req[p] && !mem_gnt[p]) begin
               gnt_cnt[p]   = $random(resp_seed) & 3;
               pend_addr[p] = mem_addr[p];
            end
            if (gnt_cnt[p] == 0) begin
               mem_gnt[p] <= 1'b1;
               gnt_cnt[p] = -1;
               val_cnt[p] = 1 + ($random(resp_seed) & 1);
            end else if (gnt_cnt[p] > 0) begin
               gnt_cnt[p] = gnt_cnt[p] - 1; // withhold grant
            end
         end
      end
   end

   // one bus access returning read data and mac_clken cycles seen
   task automatic bus_access(input logic wen, input addr_t a, input word_t d,
                             input logic [3:0] be, output word_t rdata, output int clken_cnt);
      int waited;
      int cycles;
      clken_cnt = 0;
      cycles    = 0;
      @(posedge CLK);
      lint_req   <= 1'b1;
      lint_wen   <= wen;
      lint_addr  <= a;
      lint_wdata <= d;
      lint_be    <= be;
      waited = 0;
      do begin
         @(posedge CLK);
         clken_cnt += mac_clken;
         waited++;
         if (waited > TIMEOUT) begin
            stop_failed("timed out waiting for lint_gnt");
         end
      end while (!lint_gnt);
      lint_req <= 1'b0;
      cycles = waited;
      waited = 0;
      do begin
         @(posedge CLK);
         clken_cnt += mac_clken;
         waited++;
         if (waited > TIMEOUT) begin
            stop_failed("timed out waiting for lint_valid");
         end
      end while (!lint_valid);
      cycles += waited;
      rdata = lint_rdata;
      check_word("access latency", word_t'(cycles), wen ? 32'd5 : 32'd3);
      if (!wen) begin
         model_write(a, d, be);
      end
   endtask

   task automatic read_check(input addr_t a);
      word_t rd;
      int    n;
      bus_access(1'b1, a, '0, 4'hf, rd, n);
      check_word($sformatf("lint_rdata[%h]", a), rd, model_read(a, fpgaio_in));
   endtask

   task automatic check_pins();
      mac_ctrl_u got;
      mac_ctrl_u exp;
      exp          = m_mac;
      exp.f.pad_hi = '0;
      exp.f.pad_lo = '0;
      got          = '0;
      got.f.outsel = mac_outsel;
      got.f.tc     = mac_tc;
      got.f.mode   = mac_mode;
      got.f.osel   = mac_osel;
      got.f.csel   = mac_csel;
      got.f.rnd    = mac_rnd;
      got.f.clr    = mac_clr;
      got.f.sat    = mac_sat;
      got.f.reset  = mac_reset;
      check_mac("mac pins", got, exp);
      check_io("fpgaio_out", fpgaio_out, m_out);
      check_io("fpgaio_oe", fpgaio_oe, m_oe);
      check_bit("tcdm_req_p0", mem_req[0], 1'b0);
      check_bit("tcdm_req_p1", mem_req[1], 1'b0);
   endtask

   task automatic tcdm_transfer(input int p, input logic wen);
      tcdm_cfg_u cfg;
      tcdm_cfg_u pins;
      word_t     d;
      word_t     rd;
      int        n;
      int        waited;
      logic      gnt_seen;
      cfg.raw   = $random(seed);
      cfg.f.wen = wen;
      d         = $random(seed);
      bus_access(1'b0, A_TCDM_CFG + addr_t'(4 * p), cfg.raw, 4'hf, rd, n);
      read_check(A_TCDM_CFG + addr_t'(4 * p));
      bus_access(1'b0, A_TCDM_DATA + addr_t'(4 * p), d, 4'hf, rd, n);
      check_bit($sformatf("tcdm_req_p%0d", p), mem_req[p], 1'b1);
      gnt_seen = 1'b0;
      waited   = 0;
      while (mem_req[p]) begin
         pins        = m_cfg[p];
         pins.f.wen  = mem_wen[p];
         pins.f.be_n = ~mem_be[p];
         pins.f.addr = mem_addr[p];
         check_cfg($sformatf("tcdm pins p%0d", p), pins, m_cfg[p]);
         check_word($sformatf("tcdm_wdata_p%0d", p), mem_wdata[p], d);
         if (mem_gnt[p]) begin
            gnt_seen = 1'b1;
         end
         @(posedge CLK);
         waited++;
         if (waited > TIMEOUT) begin
            stop_failed("timed out waiting for tcdm req to fall");
         end
      end
      if (!gnt_seen) begin
         stop_failed("tcdm req fell without a grant");
      end
      waited = 0;
      while (!mem_valid[p]) begin
         @(posedge CLK);
         waited++;
         if (waited > TIMEOUT) begin
            stop_failed("timed out waiting for tcdm valid");
         end
      end
      m_result[p] = {12'h000, m_cfg[p].f.addr} ^ 32'h5a5a_0000;
      read_check(A_TCDM_DATA + addr_t'(4 * p));
   endtask

   // mostly mapped addresses and some anywhere in the map
   function automatic addr_t read_target(input int unsigned r);
      case (r % 8)
         0: return A_TCDM_CFG + addr_t'(4 * ((r >> 3) % 2));
         1: return A_MAC_CTRL;
         2: return A_IO_OUT + addr_t'(4 * ((r >> 3) % 3));
         3: return A_IO_OE + addr_t'(4 * ((r >> 3) % 3));
         4: return A_IO_IN + addr_t'(4 * ((r >> 3) % 3));
         5: return A_TCDM_DATA + addr_t'(4 * ((r >> 3) % 2));
         6: return A_ID;
         default: return addr_t'(r) & 20'hffffc;
      endcase
   endfunction

   initial begin
      word_t       rd;
      word_t       rnd;
      word_t       be_rnd;
      io_t         fin;
      addr_t       a;
      int          n;
      int unsigned op;
      rst        = 1'b1;
      lint_req   = 1'b0;
      lint_wen   = 1'b0;
      lint_addr  = '0;
      lint_wdata = '0;
      lint_be    = '0;
      fpgaio_in  = '0;
      for (int p = 0; p < N_TCDM; p++) begin
         mem_gnt[p]   = 1'b0;
         mem_valid[p] = 1'b0;
         mem_rdata[p] = '0;
      end
      model_reset();
      repeat (3) @(posedge CLK);
      rst <= 1'b0;
      @(posedge CLK);
      check_bit("lint_gnt", lint_gnt, 1'b0);
      check_bit("lint_valid", lint_valid, 1'b0);
      check_bit("mac_clken", mac_clken, 1'b0);
      check_pins();
      read_check(A_ID);
      read_check(20'h00ffc);
      for (int p = 0; p < N_TCDM; p++) begin
         tcdm_transfer(p, 1'b0);
         tcdm_transfer(p, 1'b1);
      end
      for (int i = 0; i < N_OPS; i++) begin
         op  = $random(seed);
         rnd = $random(seed);
         case (op % 8)
            0, 1: begin
               be_rnd = $random(seed);
               bus_access(1'b0, A_MAC_CTRL, rnd, be_rnd[3:0], rd, n);
               read_check(A_MAC_CTRL);
            end
            2: begin
               a = (op[3] ? A_IO_OE : A_IO_OUT) + addr_t'(4 * ((op >> 4) % 3));
               bus_access(1'b0, a, rnd, 4'hf, rd, n);
               read_check(a);
            end
            3: begin
               bus_access(1'b0, A_MAC_CLKEN, rnd, 4'hf, rd, n);
               check_word("mac_clken cycles", word_t'(n), 32'd1);
            end
            4: begin
               tcdm_transfer(int'(op[3]), op[4]);
            end
            5: begin
               @(posedge CLK);
               fin[31:0]  = rnd;
               fin[63:32] = $random(seed);
               rnd        = $random(seed);
               fin[79:64] = rnd[15:0];
               fpgaio_in <= fin;
               read_check(A_IO_IN + addr_t'(4 * ((op >> 3) % 3)));
            end
            default: begin
               read_check(read_target(rnd));
            end
         endcase
         check_pins();
      end
      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire
